/* sources.f */
+incdir+testbench
logic/car_pkg.sv
logic/sensor_sampler.sv
logic/tracker_sensor.sv
logic/motor_mix.sv
logic/motor_pwm.sv
logic/car_top.sv
testbench/tb_car_top.sv

/* run.sh */
#!/bin/sh
# build and run the car testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_car_top -o sim_car
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_car)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench reported it
if echo "$output" | grep -q "Result: PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* testbench/tb_car_model.svh */
`ifndef TB_CAR_MODEL_SVH
`define TB_CAR_MODEL_SVH

// steering rules, one step per clock
function automatic car_pkg::steer_t model_next_state(
    input car_pkg::steer_t       s,
    input car_pkg::sensor_bits_t sens
);
    case (s)
        car_pkg::go_straight: begin
            if (!sens.left && sens.right) begin
                return car_pkg::turn_right;
            end
            if (sens.left && !sens.right) begin
                return car_pkg::turn_left;
            end
            return car_pkg::go_straight;
        end
        car_pkg::turn_left: begin
            if (sens.right) begin
                return car_pkg::go_straight;
            end
            return sens.mid ? car_pkg::turn_left : car_pkg::sharp_turn_left;
        end
        car_pkg::turn_right: begin
            if (sens.left) begin
                return car_pkg::go_straight;
            end
            return sens.mid ? car_pkg::turn_right : car_pkg::sharp_turn_right;
        end
        car_pkg::sharp_turn_left: begin
            return sens.mid ? car_pkg::turn_left : car_pkg::sharp_turn_left;
        end
        car_pkg::sharp_turn_right: begin
            return sens.mid ? car_pkg::turn_right : car_pkg::sharp_turn_right;
        end
        default: begin
            return car_pkg::go_straight;
        end
    endcase
endfunction

// a held pattern keeps stepping the machine until nothing changes
function automatic car_pkg::steer_t model_settle(
    input car_pkg::steer_t       s,
    input car_pkg::sensor_bits_t sens
);
    car_pkg::steer_t cur;
    cur = s;
    // longest chain is three steps, fixed points are absorbing
    repeat (8) begin
        cur = model_next_state(cur, sens);
    end
    return cur;
endfunction

// speed table: cruise 200, turn 120, pivot 100 in reverse
function automatic car_pkg::wheel_cmd_t model_wheel(
    input car_pkg::steer_t s,
    input bit              left_side
);
    car_pkg::wheel_cmd_t cmd;
    cmd.duty    = 8'd200;
    cmd.forward = 1'b1;
    if ((s == car_pkg::turn_left && left_side) || (s == car_pkg::turn_right && !left_side)) begin
        cmd.duty = 8'd120;
    end
    if ((s == car_pkg::sharp_turn_left && left_side)
            || (s == car_pkg::sharp_turn_right && !left_side)) begin
        cmd.duty    = 8'd100;
        cmd.forward = 1'b0;
    end
    return cmd;
endfunction

// new pattern only counts once held past sync plus debounce
function automatic car_pkg::sensor_bits_t accepted_value(
    input car_pkg::sensor_bits_t old_value,
    input car_pkg::sensor_bits_t new_value,
    input int                    held_cycles
);
    if (held_cycles > 2 + car_pkg::DEBOUNCE_CYCLES) begin
        return new_value;
    end
    return old_value;
endfunction

`endif

/* testbench/tb_car_top.sv */
`timescale 1ns/1ps

module tb_car_top;

    `include "tb_car_model.svh"

    localparam int RESET_CYCLES   = 16;
    localparam int HOLD_CYCLES    = 2 + car_pkg::DEBOUNCE_CYCLES + 2;
    localparam int SETTLE_TIMEOUT = 64;
    localparam int PWM_PERIOD     = 256;
    localparam int WRAP_TIMEOUT   = 2 * PWM_PERIOD;
    localparam int RANDOM_STEPS   = 40;
    // bit order {left, mid, right}, walks every state and every exit
    localparam logic [2:0] DIRECTED [0:14] = '{
        3'b111, 3'b011, 3'b111, 3'b001, 3'b011, 3'b001, 3'b111, 3'b110,
        3'b111, 3'b100, 3'b110, 3'b100, 3'b111, 3'b000, 3'b101
    };

    logic            clk;
    logic            reset;
    logic            left_signal;
    logic            mid_signal;
    logic            right_signal;
    car_pkg::steer_t steer;
    logic            left_pwm;
    logic            left_forward;
    logic            right_pwm;
    logic            right_forward;

    // model side: pins on the floor, accepted pattern, expected state
    car_pkg::sensor_bits_t applied;
    car_pkg::sensor_bits_t accepted;
    car_pkg::steer_t       model_state;
    bit                    glitch_window = 1'b0;
    int                    seed = 52757;

    car_top car_i (
        .clk           (clk),
        .reset         (reset),
        .left_signal   (left_signal),
        .mid_signal    (mid_signal),
        .right_signal  (right_signal),
        .steer         (steer),
        .left_pwm      (left_pwm),
        .left_forward  (left_forward),
        .right_pwm     (right_pwm),
        .right_forward (right_forward)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // pwm must stay low while reset is held
    assert property (@(posedge clk) reset |=> (!left_pwm && !right_pwm))
        else fail_run($sformatf("Mismatch at %0t: pwm high during reset", $time));

    // steer holds still while a short glitch is on the pins
    assert property (@(posedge clk) disable iff (reset) glitch_window |-> $stable(steer))
        else fail_run($sformatf("Mismatch at %0t: steer moved to %s on a glitch",
                                $time, steer.name()));

    task automatic drive_pins(input car_pkg::sensor_bits_t p);
        applied      = p;
        left_signal  = p.left;
        mid_signal   = p.mid;
        right_signal = p.right;
    endtask

    task automatic wait_steer(input car_pkg::steer_t expected);
        int n;
        n = 0;
        while (steer != expected && n < SETTLE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (steer == expected)
            else fail_run($sformatf("Mismatch at %0t: steer %s, expected %s",
                                    $time, steer.name(), expected.name()));
        repeat (4) @(negedge clk);
        assert (steer == expected)
            else fail_run($sformatf("Mismatch at %0t: steer left %s after settling",
                                    $time, expected.name()));
    endtask

    // period start shows as a rising edge on the left pwm
    task automatic wait_wrap();
        bit seen_low;
        bit done;
        int n;
        seen_low = 1'b0;
        done     = 1'b0;
        n        = 0;
        while (!done && n < WRAP_TIMEOUT) begin
            @(negedge clk);
            n++;
            if (!left_pwm) begin
                seen_low = 1'b1;
            end else if (seen_low) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            fail_run("timeout: left pwm never started a new period");
        end
    endtask

    // count high cycles over one full period, second wrap onward
    task automatic check_drive();
        car_pkg::wheel_cmd_t exp_left;
        car_pkg::wheel_cmd_t exp_right;
        int left_high;
        int right_high;
        exp_left   = model_wheel(model_state, 1'b1);
        exp_right  = model_wheel(model_state, 1'b0);
        left_high  = 0;
        right_high = 0;
        wait_wrap();
        wait_wrap();
        repeat (PWM_PERIOD) begin
            left_high  += int'(left_pwm);
            right_high += int'(right_pwm);
            @(negedge clk);
        end
        assert (left_high == int'(exp_left.duty) && right_high == int'(exp_right.duty))
            else fail_run($sformatf("Mismatch at %0t: %s duty %0d/%0d, expected %0d/%0d",
                                    $time, model_state.name(), left_high, right_high,
                                    exp_left.duty, exp_right.duty));
        assert (left_forward == exp_left.forward && right_forward == exp_right.forward)
            else fail_run($sformatf("Mismatch at %0t: %s forward %b/%b", $time,
                                    model_state.name(), left_forward, right_forward));
    endtask

    task automatic apply_pattern(input car_pkg::sensor_bits_t pattern);
        drive_pins(pattern);
        repeat (HOLD_CYCLES) @(negedge clk);
        accepted    = accepted_value(accepted, pattern, HOLD_CYCLES);
        model_state = model_settle(model_state, accepted);
        wait_steer(model_state);
        check_drive();
    endtask

    // short pulse of another pattern, then back to the held one
    task automatic check_glitch();
        car_pkg::sensor_bits_t held;
        car_pkg::sensor_bits_t glitch;
        int rand_val;
        int len;
        held     = applied;
        rand_val = $random(seed);
        glitch   = car_pkg::sensor_bits_t'(rand_val[2:0]);
        if (glitch == held) begin
            glitch = car_pkg::sensor_bits_t'(~held);
        end
        rand_val      = $random(seed);
        len           = 1 + ((rand_val & 32'h7fff_ffff) % (car_pkg::DEBOUNCE_CYCLES - 1));
        glitch_window = 1'b1;
        drive_pins(glitch);
        repeat (len) @(negedge clk);
        drive_pins(held);
        repeat (HOLD_CYCLES) @(negedge clk);
        glitch_window = 1'b0;
        accepted      = accepted_value(accepted, glitch, len);
        assert (steer == model_settle(model_state, accepted))
            else fail_run($sformatf("Mismatch at %0t: steer %s after a glitch",
                                    $time, steer.name()));
    endtask

    initial begin
        int rand_val;
        reset       = 1'b1;
        accepted    = car_pkg::SENSORS_WHITE;
        model_state = car_pkg::go_straight;
        drive_pins(car_pkg::SENSORS_WHITE);
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            assert (steer == car_pkg::go_straight && left_forward && right_forward
                    && !left_pwm && !right_pwm)
                else fail_run($sformatf("Mismatch at %0t: outputs off reset values", $time));
        end
        reset = 1'b0;
        @(negedge clk);
        assert (steer == car_pkg::go_straight && left_forward && right_forward)
            else fail_run($sformatf("Mismatch at %0t: outputs moved after reset", $time));

        // directed walk, with a glitch in each settled state
        for (int i = 0; i < 15; i++) begin
            apply_pattern(car_pkg::sensor_bits_t'(DIRECTED[i]));
            check_glitch();
        end

        // random patterns from the fixed seed
        for (int i = 0; i < RANDOM_STEPS; i++) begin
            rand_val = $random(seed);
            apply_pattern(car_pkg::sensor_bits_t'(rand_val[2:0]));
            if (i % 4 == 0) begin
                check_glitch();
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* logic/car_top.sv */
`timescale 1ns/1ps

module car_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            left_signal,
    input  logic            mid_signal,
    input  logic            right_signal,
    output car_pkg::steer_t steer,
    output logic            left_pwm,
    output logic            left_forward,
    output logic            right_pwm,
    output logic            right_forward
);

    // raw floor pins as one group
    car_pkg::sensor_bits_t sensors_raw;
    car_pkg::sensor_bits_t sensors_clean;

    car_pkg::wheel_cmd_t left_cmd;
    car_pkg::wheel_cmd_t right_cmd;

    assign sensors_raw = '{left: left_signal, mid: mid_signal, right: right_signal};

    sensor_sampler sampler_i (
        .clk           (clk),
        .reset         (reset),
        .sensors_raw   (sensors_raw),
        .sensors_clean (sensors_clean)
    );

    // steering state goes out as steer and into the mixer
    tracker_sensor tracker_i (
        .clk     (clk),
        .reset   (reset),
        .sensors (sensors_clean),
        .state   (steer)
    );

    motor_mix mix_i (
        .clk       (clk),
        .reset     (reset),
        .state     (steer),
        .left_cmd  (left_cmd),
        .right_cmd (right_cmd)
    );

    // one pwm generator per wheel
    motor_pwm left_pwm_i (
        .clk     (clk),
        .reset   (reset),
        .cmd     (left_cmd),
        .pwm     (left_pwm),
        .forward (left_forward)
    );

    motor_pwm right_pwm_i (
        .clk     (clk),
        .reset   (reset),
        .cmd     (right_cmd),
        .pwm     (right_pwm),
        .forward (right_forward)
    );

endmodule

/* logic/motor_pwm.sv */
`timescale 1ns/1ps

module motor_pwm (
    input  logic                clk,
    input  logic                reset,
    input  car_pkg::wheel_cmd_t cmd,
    output logic                pwm,
    output logic                forward
);

    logic [car_pkg::DUTY_BITS-1:0] count;
    // duty in effect for the running period
    logic [car_pkg::DUTY_BITS-1:0] duty_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            count   <= '0;
            duty_q  <= '0;
            forward <= 1'b1;
            pwm     <= 1'b0;
        end else begin
            count <= count + 1'b1;
            // take new command only as the counter wraps
            if (&count) begin
                duty_q  <= cmd.duty;
                forward <= cmd.forward;
            end
            // exactly duty_q high cycles per period
            pwm <= (count < duty_q);
        end
    end

endmodule

/* logic/motor_mix.sv */
`timescale 1ns/1ps

module motor_mix (
    input  logic                clk,
    input  logic                reset,
    input  car_pkg::steer_t     state,
    output car_pkg::wheel_cmd_t left_cmd,
    output car_pkg::wheel_cmd_t right_cmd
);

    car_pkg::wheel_cmd_t left_next;
    car_pkg::wheel_cmd_t right_next;

    // speed table, inner wheel slows or reverses
    always_comb begin
        left_next  = car_pkg::WHEEL_CRUISE;
        right_next = car_pkg::WHEEL_CRUISE;
        case (state)
            car_pkg::turn_left:        left_next  = car_pkg::WHEEL_TURN;
            car_pkg::turn_right:       right_next = car_pkg::WHEEL_TURN;
            car_pkg::sharp_turn_left:  left_next  = car_pkg::WHEEL_PIVOT_REV;
            car_pkg::sharp_turn_right: right_next = car_pkg::WHEEL_PIVOT_REV;
            // straight and unused codes keep both at cruise
            default: begin
                left_next  = car_pkg::WHEEL_CRUISE;
                right_next = car_pkg::WHEEL_CRUISE;
            end
        endcase
    end

    // one cycle behind the steering state
    always_ff @(posedge clk) begin
        if (reset) begin
            left_cmd  <= car_pkg::WHEEL_CRUISE;
            right_cmd <= car_pkg::WHEEL_CRUISE;
        end else begin
            left_cmd  <= left_next;
            right_cmd <= right_next;
        end
    end

endmodule

/* logic/tracker_sensor.sv */
`timescale 1ns/1ps

module tracker_sensor (
    input  logic                  clk,
    input  logic                  reset,
    input  car_pkg::sensor_bits_t sensors,
    output car_pkg::steer_t       state
);

    car_pkg::steer_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= car_pkg::go_straight;
        end else begin
            state <= next_state;
        end
    end

    // steering policy, black is low
    always_comb begin
        case (state)
            car_pkg::go_straight: begin
                // line drifted under one side
                if (!sensors.left && sensors.right) begin
                    next_state = car_pkg::turn_right;
                end else if (sensors.left && !sensors.right) begin
                    next_state = car_pkg::turn_left;
                end else begin
                    next_state = car_pkg::go_straight;
                end
            end
            car_pkg::turn_left: begin
                if (sensors.right) begin
                    next_state = car_pkg::go_straight;
                end else if (!sensors.mid) begin
                    // mid lost the line too, tighten
                    next_state = car_pkg::sharp_turn_left;
                end else begin
                    next_state = car_pkg::turn_left;
                end
            end
            car_pkg::turn_right: begin
                if (sensors.left) begin
                    next_state = car_pkg::go_straight;
                end else if (!sensors.mid) begin
                    next_state = car_pkg::sharp_turn_right;
                end else begin
                    next_state = car_pkg::turn_right;
                end
            end
            car_pkg::sharp_turn_left: begin
                // back off once mid sees white
                if (sensors.mid) begin
                    next_state = car_pkg::turn_left;
                end else begin
                    next_state = car_pkg::sharp_turn_left;
                end
            end
            car_pkg::sharp_turn_right: begin
                if (sensors.mid) begin
                    next_state = car_pkg::turn_right;
                end else begin
                    next_state = car_pkg::sharp_turn_right;
                end
            end
            default: begin
                // unused codes recover to straight
                next_state = car_pkg::go_straight;
            end
        endcase
    end

endmodule

/* logic/sensor_sampler.sv */
`timescale 1ns/1ps

module sensor_sampler (
    input  logic                  clk,
    input  logic                  reset,
    input  car_pkg::sensor_bits_t sensors_raw,
    output car_pkg::sensor_bits_t sensors_clean
);

    // two-stage synchronizer for the async pins
    car_pkg::sensor_bits_t sync_meta;
    car_pkg::sensor_bits_t sync_q;

    // pattern under test and how long it has held
    car_pkg::sensor_bits_t               candidate;
    logic [car_pkg::DEBOUNCE_BITS-1:0]   stable_count;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta <= car_pkg::SENSORS_WHITE;
            sync_q    <= car_pkg::SENSORS_WHITE;
        end else begin
            sync_meta <= sensors_raw;
            sync_q    <= sync_meta;
        end
    end

    // whole group debounced as one word
    // so the tracker never sees a half-updated pattern
    always_ff @(posedge clk) begin
        if (reset) begin
            candidate     <= car_pkg::SENSORS_WHITE;
            stable_count  <= '0;
            sensors_clean <= car_pkg::SENSORS_WHITE;
        end else if (sync_q != candidate) begin
            // new pattern, first sample already seen
            candidate    <= sync_q;
            stable_count <= car_pkg::DEBOUNCE_BITS'(1);
        end else if (stable_count != car_pkg::DEBOUNCE_LAST) begin
            stable_count <= stable_count + 1'b1;
        end else begin
            // held long enough, pass it on
            sensors_clean <= candidate;
        end
    end

endmodule

/* logic/car_pkg.sv */
package car_pkg;

    // floor sensor group
    // each bit low on black and high on white
    typedef struct packed {
        logic left;
        logic mid;
        logic right;
    } sensor_bits_t;

    // steering actions with their fixed codes
    typedef enum logic [2:0] {
        turn_left        = 3'd0,
        turn_right       = 3'd1,
        go_straight      = 3'd2,
        sharp_turn_left  = 3'd3,
        sharp_turn_right = 3'd4
    } steer_t;

    // pwm counter and duty width
    // period is 2**DUTY_BITS clocks
    localparam int DUTY_BITS = 8;

    // high counts per period plus direction for one wheel
    typedef struct packed {
        logic [DUTY_BITS-1:0] duty;
        logic                 forward;
    } wheel_cmd_t;

    // speed table
    // outer wheel or both wheels going straight
    localparam logic [DUTY_BITS-1:0] SPEED_CRUISE = 8'd200;
    // inner wheel on a normal turn
    localparam logic [DUTY_BITS-1:0] SPEED_TURN = 8'd120;
    // inner wheel on a sharp turn runs backwards
    localparam logic [DUTY_BITS-1:0] SPEED_PIVOT = 8'd100;

    // ready-made wheel commands for the mixer
    localparam wheel_cmd_t WHEEL_CRUISE = '{duty: SPEED_CRUISE, forward: 1'b1};
    localparam wheel_cmd_t WHEEL_TURN = '{duty: SPEED_TURN, forward: 1'b1};
    localparam wheel_cmd_t WHEEL_PIVOT_REV = '{duty: SPEED_PIVOT, forward: 1'b0};

    // debounce timing
    // equal synchronized samples needed before a new pattern is taken
    localparam int DEBOUNCE_CYCLES = 8;
    // stability counter runs 1 .. DEBOUNCE_CYCLES-1
    localparam int DEBOUNCE_BITS = $clog2(DEBOUNCE_CYCLES);
    localparam logic [DEBOUNCE_BITS-1:0] DEBOUNCE_LAST = DEBOUNCE_BITS'(DEBOUNCE_CYCLES - 1);

    // all sensors on white is the idle value after reset
    localparam sensor_bits_t SENSORS_WHITE = '{left: 1'b1, mid: 1'b1, right: 1'b1};

endpackage
